/* hdl/bpPkg.sv */
package bpPkg;

    // ----------------------------------------
    // Table geometry and counter encoding
    // ----------------------------------------
    localparam int ADDR_W    = 32;
    localparam int WAYS      = 4;
    localparam int COUNTER_W = 2;

    // Weakly taken
    localparam logic [COUNTER_W-1:0] COUNTER_INIT = 2'b10;
    localparam logic [COUNTER_W-1:0] COUNTER_MAX  = 2'b11;
    localparam logic [COUNTER_W-1:0] COUNTER_MIN  = 2'b00;

    // Repair actions sent back by the functional unit
    localparam int ACTION_W = 2;
    localparam logic [ACTION_W-1:0] ACT_NONE   = 2'd0;
    localparam logic [ACTION_W-1:0] ACT_REPAIR = 2'd1;
    localparam logic [ACTION_W-1:0] ACT_DIRECT = 2'd2;

    // ----------------------------------------
    // Wishbone register map
    // ----------------------------------------
    localparam int WB_ADR_W = 2;
    localparam int WB_DAT_W = 32;

    localparam logic [WB_ADR_W-1:0] REG_CTRL    = 2'd0;
    localparam logic [WB_ADR_W-1:0] REG_STATUS  = 2'd1;
    localparam logic [WB_ADR_W-1:0] REG_UPDATES = 2'd2;
    localparam logic [WB_ADR_W-1:0] REG_MISPRED = 2'd3;

endpackage

/* hdl/phtBank.sv */
`timescale 1ns/1ps

module phtBank #(
    parameter int ENTRIES = 256
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [$clog2(ENTRIES)-1:0]    rdIndex_i,
    input  logic                          wrEn_i,
    input  logic [$clog2(ENTRIES)-1:0]    wrIndex_i,
    input  logic [bpPkg::COUNTER_W-1:0]   wrData_i,
    input  logic                          sweepEn_i,
    input  logic [$clog2(ENTRIES)-1:0]    sweepIndex_i,
    output logic [bpPkg::COUNTER_W-1:0]   rdData_o,
    output logic                          rdValid_o
);

    logic [bpPkg::COUNTER_W-1:0] counters [ENTRIES];
    logic [ENTRIES-1:0]          valid;

    // Counter storage, sweep wins over the update port
    always_ff @(posedge clk) begin
        if (sweepEn_i) begin
            counters[sweepIndex_i] <= bpPkg::COUNTER_INIT;
        end else if (wrEn_i) begin
            counters[wrIndex_i] <= wrData_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid <= '0;
        end else if (sweepEn_i) begin
            valid[sweepIndex_i] <= 1'b0;
        end else if (wrEn_i) begin
            valid[wrIndex_i] <= 1'b1;
        end
    end

    // Registered read with same-entry forwarding.
    // An entry with valid clear always holds the init value, so it is
    // returned directly and unswept storage is never seen.
    always_ff @(posedge clk) begin
        if (!rst) begin
            rdData_o  <= bpPkg::COUNTER_INIT;
            rdValid_o <= 1'b0;
        end else if (sweepEn_i) begin
            rdData_o  <= bpPkg::COUNTER_INIT;
            rdValid_o <= 1'b0;
        end else if (wrEn_i && (wrIndex_i == rdIndex_i)) begin
            rdData_o  <= wrData_i;
            rdValid_o <= 1'b1;
        end else if (valid[rdIndex_i]) begin
            rdData_o  <= counters[rdIndex_i];
            rdValid_o <= 1'b1;
        end else begin
            rdData_o  <= bpPkg::COUNTER_INIT;
            rdValid_o <= 1'b0;
        end
    end

endmodule

/* hdl/phtUpdate.sv */
`timescale 1ns/1ps

module phtUpdate #(
    parameter int ENTRIES = 256
) (
    input  logic [bpPkg::ACTION_W-1:0]    updAction_i,
    input  logic                          updNeedRepair_i,
    input  logic [bpPkg::COUNTER_W-1:0]   updCheckPoint_i,
    input  logic [bpPkg::ADDR_W-1:0]      updVAddr_i,
    input  logic                          updTaken_i,
    input  logic                          busy_i,
    output logic [bpPkg::WAYS-1:0]        wrEn_o,
    output logic [$clog2(ENTRIES)-1:0]    wrIndex_o,
    output logic [bpPkg::COUNTER_W-1:0]   wrData_o,
    output logic                          accept_o,
    output logic                          mispred_o
);

    localparam int IDX_W = $clog2(ENTRIES);

    logic actionHit;
    logic atMax;
    logic atMin;

    assign actionHit = (updAction_i == bpPkg::ACT_REPAIR) || (updAction_i == bpPkg::ACT_DIRECT);
    assign accept_o  = updNeedRepair_i && actionHit && !busy_i;

    // Slot bits pick the bank
    assign wrEn_o = accept_o ? (bpPkg::WAYS'(1) << updVAddr_i[3:2]) : '0;

    // Same hash as the lookup side
    assign wrIndex_o = updVAddr_i[4 +: IDX_W] ^ updVAddr_i[4 + IDX_W +: IDX_W];

    // Saturating successor of the checkpoint
    assign atMax = (updCheckPoint_i == bpPkg::COUNTER_MAX) && updTaken_i;
    assign atMin = (updCheckPoint_i == bpPkg::COUNTER_MIN) && !updTaken_i;

    always_comb begin
        if (atMax || atMin) begin
            wrData_o = updCheckPoint_i;
        end else if (updTaken_i) begin
            wrData_o = updCheckPoint_i + 1'b1;
        end else begin
            wrData_o = updCheckPoint_i - 1'b1;
        end
    end

    // Predicted direction was the top counter bit
    assign mispred_o = accept_o && (updCheckPoint_i[bpPkg::COUNTER_W-1] != updTaken_i);

endmodule

/* hdl/phtSweepFsm.sv */
`timescale 1ns/1ps

module phtSweepFsm #(
    parameter int ENTRIES = 256
) (
    input  logic clk,
    input  logic rst,
    input  logic flushReq_i,
    input  logic last_i,
    output logic sweepEn_o,
    output logic busy_o
);

    typedef enum logic {
        IDLE,
        SWEEP
    } state_t;

    state_t state;
    state_t stateNext;
    logic   startPending;
    logic   sweepDone;

    // A one-entry table is done after a single cycle
    assign sweepDone = last_i || (ENTRIES == 1);

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (startPending || flushReq_i) begin
                    stateNext = SWEEP;
                end
            end
            SWEEP: begin
                if (sweepDone) begin
                    stateNext = IDLE;
                end
            end
            default: stateNext = IDLE;
        endcase
    end

    // Sweep starts on the first edge out of reset
    always_ff @(posedge clk) begin
        if (!rst) begin
            state        <= IDLE;
            startPending <= 1'b1;
        end else begin
            state        <= stateNext;
            startPending <= 1'b0;
        end
    end

    assign sweepEn_o = (state == SWEEP);
    assign busy_o    = (state == SWEEP);

endmodule

/* hdl/sweepCounter.sv */
`timescale 1ns/1ps

module sweepCounter #(
    parameter int ENTRIES = 256
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       en_i,
    output logic [$clog2(ENTRIES)-1:0] index_o,
    output logic                       last_o
);

    localparam int IDX_W = $clog2(ENTRIES);

    assign last_o = (index_o == IDX_W'(ENTRIES - 1));

    // Wraps back to zero after the last entry
    always_ff @(posedge clk) begin
        if (!rst) begin
            index_o <= '0;
        end else if (en_i) begin
            index_o <= last_o ? '0 : index_o + 1'b1;
        end
    end

endmodule

/* hdl/phtWbRegs.sv */
`timescale 1ns/1ps

module phtWbRegs (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wbCyc_i,
    input  logic                         wbStb_i,
    input  logic                         wbWe_i,
    input  logic [bpPkg::WB_ADR_W-1:0]   wbAdr_i,
    input  logic [bpPkg::WB_DAT_W-1:0]   wbDat_i,
    input  logic                         accept_i,
    input  logic                         mispred_i,
    input  logic                         busy_i,
    output logic [bpPkg::WB_DAT_W-1:0]   wbDat_o,
    output logic                         wbAck_o,
    output logic                         flushReq_o
);

    logic                         wbReq;
    logic                         ctrlWrite;
    logic                         statsClear;
    logic [bpPkg::WB_DAT_W-1:0]   updCount;
    logic [bpPkg::WB_DAT_W-1:0]   mispredCount;
    logic [bpPkg::WB_DAT_W-1:0]   rdMux;

    assign wbReq = wbCyc_i && wbStb_i;

    // ----------------------------------------
    // Handshake, one wait cycle per access
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            wbAck_o <= 1'b0;
        end else begin
            wbAck_o <= wbReq && !wbAck_o;
        end
    end

    // Control write acts in the ack cycle
    assign ctrlWrite  = wbAck_o && wbReq && wbWe_i && (wbAdr_i == bpPkg::REG_CTRL);
    assign flushReq_o = ctrlWrite && wbDat_i[0];
    assign statsClear = ctrlWrite && wbDat_i[1];

    always_comb begin
        case (wbAdr_i)
            bpPkg::REG_STATUS:  rdMux = {{(bpPkg::WB_DAT_W-1){1'b0}}, busy_i};
            bpPkg::REG_UPDATES: rdMux = updCount;
            bpPkg::REG_MISPRED: rdMux = mispredCount;
            default:            rdMux = '0;
        endcase
    end

    // Read data is captured with the ack and zero otherwise
    always_ff @(posedge clk) begin
        if (!rst) begin
            wbDat_o <= '0;
        end else if (wbReq && !wbAck_o && !wbWe_i) begin
            wbDat_o <= rdMux;
        end else begin
            wbDat_o <= '0;
        end
    end

    // ----------------------------------------
    // Statistics, both counters wrap
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            updCount     <= '0;
            mispredCount <= '0;
        end else if (statsClear) begin
            updCount     <= '0;
            mispredCount <= '0;
        end else if (accept_i) begin
            updCount <= updCount + 1'b1;
            if (mispred_i) begin
                mispredCount <= mispredCount + 1'b1;
            end
        end
    end

endmodule

/* hdl/patternHistoryTop.sv */
`timescale 1ns/1ps

module patternHistoryTop #(
    parameter int ENTRIES = 256
) (
    input  logic                                        clk,
    input  logic                                        rst,
    // Lookup
    input  logic [bpPkg::ADDR_W-1:0]                    fetchVAddr_i,
    output logic [bpPkg::WAYS*bpPkg::COUNTER_W-1:0]     checkPoint_o,
    output logic [bpPkg::WAYS-1:0]                      predTake_o,
    // Resolved branch
    input  logic [bpPkg::ACTION_W-1:0]                  updAction_i,
    input  logic                                        updNeedRepair_i,
    input  logic [bpPkg::COUNTER_W-1:0]                 updCheckPoint_i,
    input  logic [bpPkg::ADDR_W-1:0]                    updVAddr_i,
    input  logic                                        updTaken_i,
    // Wishbone slave
    input  logic                                        wbCyc_i,
    input  logic                                        wbStb_i,
    input  logic                                        wbWe_i,
    input  logic [bpPkg::WB_ADR_W-1:0]                  wbAdr_i,
    input  logic [bpPkg::WB_DAT_W-1:0]                  wbDat_i,
    output logic [bpPkg::WB_DAT_W-1:0]                  wbDat_o,
    output logic                                        wbAck_o,
    output logic                                        busy_o
);

    localparam int IDX_W = $clog2(ENTRIES);

    logic [IDX_W-1:0]              rdIndex;
    logic [bpPkg::WAYS-1:0]        wrEn;
    logic [IDX_W-1:0]              wrIndex;
    logic [bpPkg::COUNTER_W-1:0]   wrData;
    logic                          accept;
    logic                          mispred;
    logic                          sweepEn;
    logic [IDX_W-1:0]              sweepIndex;
    logic                          sweepLast;
    logic                          flushReq;

    // Slot bits stay out of the hash, so every bank reads the same entry
    assign rdIndex = fetchVAddr_i[4 +: IDX_W] ^ fetchVAddr_i[4 + IDX_W +: IDX_W];

    for (genvar i = 0; i < bpPkg::WAYS; i++) begin : g_bank
        logic [bpPkg::COUNTER_W-1:0] rdData;
        logic                        rdValid;

        phtBank #(
            .ENTRIES (ENTRIES)
        ) i_phtBank (
            .clk          (clk),
            .rst          (rst),
            .rdIndex_i    (rdIndex),
            .wrEn_i       (wrEn[i]),
            .wrIndex_i    (wrIndex),
            .wrData_i     (wrData),
            .sweepEn_i    (sweepEn),
            .sweepIndex_i (sweepIndex),
            .rdData_o     (rdData),
            .rdValid_o    (rdValid)
        );

        assign checkPoint_o[i*bpPkg::COUNTER_W +: bpPkg::COUNTER_W] = rdData;
        assign predTake_o[i] = rdValid && rdData[bpPkg::COUNTER_W-1];
    end

    phtUpdate #(
        .ENTRIES (ENTRIES)
    ) i_phtUpdate (
        .updAction_i     (updAction_i),
        .updNeedRepair_i (updNeedRepair_i),
        .updCheckPoint_i (updCheckPoint_i),
        .updVAddr_i      (updVAddr_i),
        .updTaken_i      (updTaken_i),
        .busy_i          (busy_o),
        .wrEn_o          (wrEn),
        .wrIndex_o       (wrIndex),
        .wrData_o        (wrData),
        .accept_o        (accept),
        .mispred_o       (mispred)
    );

    phtSweepFsm #(
        .ENTRIES (ENTRIES)
    ) i_phtSweepFsm (
        .clk        (clk),
        .rst        (rst),
        .flushReq_i (flushReq),
        .last_i     (sweepLast),
        .sweepEn_o  (sweepEn),
        .busy_o     (busy_o)
    );

    sweepCounter #(
        .ENTRIES (ENTRIES)
    ) i_sweepCounter (
        .clk     (clk),
        .rst     (rst),
        .en_i    (sweepEn),
        .index_o (sweepIndex),
        .last_o  (sweepLast)
    );

    phtWbRegs i_phtWbRegs (
        .clk        (clk),
        .rst        (rst),
        .wbCyc_i    (wbCyc_i),
        .wbStb_i    (wbStb_i),
        .wbWe_i     (wbWe_i),
        .wbAdr_i    (wbAdr_i),
        .wbDat_i    (wbDat_i),
        .accept_i   (accept),
        .mispred_i  (mispred),
        .busy_i     (busy_o),
        .wbDat_o    (wbDat_o),
        .wbAck_o    (wbAck_o),
        .flushReq_o (flushReq)
    );

endmodule

/* tests/phtChecker.sv */
`timescale 1ns/1ps

module phtChecker #(
    parameter int ENTRIES = 256
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic [bpPkg::ADDR_W-1:0]                fetchVAddr_i,
    input  logic [bpPkg::ACTION_W-1:0]              updAction_i,
    input  logic                                    updNeedRepair_i,
    input  logic [bpPkg::COUNTER_W-1:0]             updCheckPoint_i,
    input  logic [bpPkg::ADDR_W-1:0]                updVAddr_i,
    input  logic                                    updTaken_i,
    input  logic                                    wbCyc_i,
    input  logic                                    wbStb_i,
    input  logic                                    wbWe_i,
    input  logic [bpPkg::WB_ADR_W-1:0]              wbAdr_i,
    input  logic [bpPkg::WB_DAT_W-1:0]              wbWrDat_i,
    input  logic [bpPkg::WB_DAT_W-1:0]              wbRdDat_i,
    input  logic                                    wbAck_i,
    input  logic [bpPkg::WAYS*bpPkg::COUNTER_W-1:0] checkPoint_i,
    input  logic [bpPkg::WAYS-1:0]                  predTake_i,
    input  logic                                    busy_i,
    output int                                      checks_o,
    output int                                      lookupErrors_o,
    output int                                      busyErrors_o,
    output int                                      wbErrors_o
);

    localparam int IDX_W = $clog2(ENTRIES);
    localparam int CW    = bpPkg::COUNTER_W;
    localparam int WAYS  = bpPkg::WAYS;
    localparam logic [CW-1:0] CNT_MAX = '1;

    // Model of table, sweep timer and statistics
    logic [CW-1:0]      modelCnt [WAYS][ENTRIES];
    logic [ENTRIES-1:0] modelValid [WAYS];
    logic [31:0]        modelUpdates;
    logic [31:0]        modelMispred;
    int                 busyLeft = 0;
    logic               startPending = 1'b0;

    // Outputs expected after the next rising edge
    logic               expKnown = 1'b0;
    logic [CW-1:0]      expCp [WAYS];
    logic               expValid [WAYS];
    logic               expAck;
    logic               expRead;
    logic [31:0]        expRdDat;

    int checks = 0;
    int lookupErrors = 0;
    int busyErrors = 0;
    int wbErrors = 0;

    assign checks_o       = checks;
    assign lookupErrors_o = lookupErrors;
    assign busyErrors_o   = busyErrors;
    assign wbErrors_o     = wbErrors;

    function automatic logic [IDX_W-1:0] hashIndex(input logic [bpPkg::ADDR_W-1:0] addr);
        return addr[4 +: IDX_W] ^ addr[4 + IDX_W +: IDX_W];
    endfunction

    function automatic logic [CW-1:0] nextCount(input logic [CW-1:0] cp, input logic taken);
        if (taken) begin
            return (cp == CNT_MAX) ? cp : cp + 1'b1;
        end
        return (cp == '0) ? cp : cp - 1'b1;
    endfunction

    // ----------------------------------------
    // Compare DUT outputs with the model
    // ----------------------------------------
    task automatic compareOutputs();
        int            i;
        logic [CW-1:0] cp;
        logic          expTake;
        for (i = 0; i < WAYS; i++) begin
            cp = checkPoint_i[i*CW +: CW];
            expTake = expValid[i] && expCp[i][CW-1];
            checks += 2;
            if (cp !== expCp[i]) begin
                lookupErrors++;
                $display("ERROR checkPoint_o[%0d] got 0x%h expected 0x%h at %0t",
                         i, cp, expCp[i], $time);
            end
            if (predTake_i[i] !== expTake) begin
                lookupErrors++;
                $display("ERROR predTake_o[%0d] got 0x%h expected 0x%h at %0t",
                         i, predTake_i[i], expTake, $time);
            end
        end
        checks += 2;
        if (busy_i !== (busyLeft > 0)) begin
            busyErrors++;
            $display("ERROR busy_o got 0x%h expected 0x%h at %0t",
                     busy_i, (busyLeft > 0), $time);
        end
        if (wbAck_i !== expAck) begin
            wbErrors++;
            $display("ERROR wbAck_o got 0x%h expected 0x%h at %0t", wbAck_i, expAck, $time);
        end
        if (expAck && expRead) begin
            checks++;
            if (wbRdDat_i !== expRdDat) begin
                wbErrors++;
                $display("ERROR wbDat_o got 0x%h expected 0x%h at %0t",
                         wbRdDat_i, expRdDat, $time);
            end
        end
    endtask

    // ----------------------------------------
    // Advance the model by one rising edge
    // ----------------------------------------
    task automatic stepModel();
        int               i;
        logic             preBusy;
        logic             req;
        logic             ctrlWrite;
        logic             accept;
        logic [1:0]       bank;
        logic [IDX_W-1:0] rdIdx;
        logic [IDX_W-1:0] wrIdx;
        logic [CW-1:0]    newCnt;
        if (!rst) begin
            for (i = 0; i < WAYS; i++) begin
                modelValid[i] = '0;
                expCp[i] = bpPkg::COUNTER_INIT;
                expValid[i] = 1'b0;
            end
            busyLeft = 0;
            startPending = 1'b1;
            modelUpdates = '0;
            modelMispred = '0;
            expAck = 1'b0;
            expRead = 1'b0;
            expKnown = 1'b1;
        end else begin
            preBusy = (busyLeft > 0);
            req = wbCyc_i && wbStb_i;
            ctrlWrite = expAck && req && wbWe_i && (wbAdr_i == bpPkg::REG_CTRL);
            accept = updNeedRepair_i && !preBusy &&
                     ((updAction_i == bpPkg::ACT_REPAIR) || (updAction_i == bpPkg::ACT_DIRECT));
            bank = updVAddr_i[3:2];
            wrIdx = hashIndex(updVAddr_i);
            newCnt = nextCount(updCheckPoint_i, updTaken_i);
            rdIdx = hashIndex(fetchVAddr_i);

            // Lookup, with the same-edge write forwarded
            for (i = 0; i < WAYS; i++) begin
                if (preBusy) begin
                    expCp[i] = bpPkg::COUNTER_INIT;
                    expValid[i] = 1'b0;
                end else if (accept && (bank == i) && (wrIdx == rdIdx)) begin
                    expCp[i] = newCnt;
                    expValid[i] = 1'b1;
                end else if (modelValid[i][rdIdx]) begin
                    expCp[i] = modelCnt[i][rdIdx];
                    expValid[i] = 1'b1;
                end else begin
                    expCp[i] = bpPkg::COUNTER_INIT;
                    expValid[i] = 1'b0;
                end
            end

            // Read data reflects the registers before this edge
            expRead = req && !expAck && !wbWe_i;
            case (wbAdr_i)
                bpPkg::REG_STATUS:  expRdDat = {31'b0, preBusy};
                bpPkg::REG_UPDATES: expRdDat = modelUpdates;
                bpPkg::REG_MISPRED: expRdDat = modelMispred;
                default:            expRdDat = '0;
            endcase
            expAck = req && !expAck;

            if (preBusy) begin
                for (i = 0; i < WAYS; i++) begin
                    modelValid[i][IDX_W'(ENTRIES - busyLeft)] = 1'b0;
                end
            end else if (accept) begin
                modelCnt[bank][wrIdx] = newCnt;
                modelValid[bank][wrIdx] = 1'b1;
            end

            if (ctrlWrite && wbWrDat_i[1]) begin
                modelUpdates = '0;
                modelMispred = '0;
            end else if (accept) begin
                modelUpdates++;
                if (updCheckPoint_i[CW-1] != updTaken_i) begin
                    modelMispred++;
                end
            end

            // Flush while sweeping is ignored
            if (preBusy) begin
                busyLeft--;
            end else if (startPending || (ctrlWrite && wbWrDat_i[0])) begin
                busyLeft = ENTRIES;
            end
            startPending = 1'b0;
        end
    endtask

    // Inputs and outputs are both settled at the falling edge
    always @(negedge clk) begin
        if (expKnown) begin
            compareOutputs();
        end
        stepModel();
    end

endmodule

/* tests/patternHistoryTb.sv */
`timescale 1ns/1ps

module patternHistoryTb;

    localparam int ENTRIES        = 256;
    localparam int RESET_CYCLES   = 10;
    localparam int RAND_FIRST     = 600;
    localparam int RAND_SECOND    = 400;
    localparam int RAND_LAST      = 300;
    localparam int STIM_CYCLES    = RESET_CYCLES + RAND_FIRST + RAND_SECOND + RAND_LAST
                                    + ENTRIES + 100;
    localparam int TIMEOUT_CYCLES = 3 * ENTRIES + STIM_CYCLES + 500;

    logic                                    clk;
    logic                                    rst;
    logic [bpPkg::ADDR_W-1:0]                fetchVAddr;
    logic [bpPkg::ACTION_W-1:0]              updAction;
    logic                                    updNeedRepair;
    logic [bpPkg::COUNTER_W-1:0]             updCheckPoint;
    logic [bpPkg::ADDR_W-1:0]                updVAddr;
    logic                                    updTaken;
    logic                                    wbCyc;
    logic                                    wbStb;
    logic                                    wbWe;
    logic [bpPkg::WB_ADR_W-1:0]              wbAdr;
    logic [bpPkg::WB_DAT_W-1:0]              wbWrDat;
    logic [bpPkg::WB_DAT_W-1:0]              wbRdDat;
    logic                                    wbAck;
    logic [bpPkg::WAYS*bpPkg::COUNTER_W-1:0] checkPoint;
    logic [bpPkg::WAYS-1:0]                  predTake;
    logic                                    busy;

    logic [15:0] lfsrState;
    int          cycleCount = 0;
    int          checks;
    int          lookupErrors;
    int          busyErrors;
    int          wbErrors;

    patternHistoryTop #(
        .ENTRIES (ENTRIES)
    ) i_patternHistoryTop (
        .clk             (clk),
        .rst             (rst),
        .fetchVAddr_i    (fetchVAddr),
        .checkPoint_o    (checkPoint),
        .predTake_o      (predTake),
        .updAction_i     (updAction),
        .updNeedRepair_i (updNeedRepair),
        .updCheckPoint_i (updCheckPoint),
        .updVAddr_i      (updVAddr),
        .updTaken_i      (updTaken),
        .wbCyc_i         (wbCyc),
        .wbStb_i         (wbStb),
        .wbWe_i          (wbWe),
        .wbAdr_i         (wbAdr),
        .wbDat_i         (wbWrDat),
        .wbDat_o         (wbRdDat),
        .wbAck_o         (wbAck),
        .busy_o          (busy)
    );

    phtChecker #(
        .ENTRIES (ENTRIES)
    ) i_phtChecker (
        .clk             (clk),
        .rst             (rst),
        .fetchVAddr_i    (fetchVAddr),
        .updAction_i     (updAction),
        .updNeedRepair_i (updNeedRepair),
        .updCheckPoint_i (updCheckPoint),
        .updVAddr_i      (updVAddr),
        .updTaken_i      (updTaken),
        .wbCyc_i         (wbCyc),
        .wbStb_i         (wbStb),
        .wbWe_i          (wbWe),
        .wbAdr_i         (wbAdr),
        .wbWrDat_i       (wbWrDat),
        .wbRdDat_i       (wbRdDat),
        .wbAck_i         (wbAck),
        .checkPoint_i    (checkPoint),
        .predTake_i      (predTake),
        .busy_i          (busy),
        .checks_o        (checks),
        .lookupErrors_o  (lookupErrors),
        .busyErrors_o    (busyErrors),
        .wbErrors_o      (wbErrors)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic drawBits(input int count, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    // Few upper bits, so entries collide often
    task automatic drawAddr(output logic [31:0] addr);
        logic [31:0] slot;
        logic [31:0] lo;
        logic [31:0] hi;
        drawBits(2, slot);
        drawBits(3, lo);
        drawBits(2, hi);
        addr = (hi << 12) | (lo << 4) | (slot << 2);
    endtask

    task automatic randomCycle();
        logic [31:0] fetchAddr;
        logic [31:0] updAddr;
        logic [31:0] action;
        logic [31:0] repair;
        logic [31:0] cp;
        logic [31:0] taken;
        logic [31:0] share;
        drawAddr(fetchAddr);
        drawAddr(updAddr);
        drawBits(2, action);
        drawBits(2, repair);
        drawBits(2, cp);
        drawBits(1, taken);
        drawBits(2, share);
        // Look up the entry being written, for the bypass
        if (share == 0) begin
            fetchAddr = updAddr;
        end
        fetchVAddr    <= fetchAddr;
        updVAddr      <= updAddr;
        updAction     <= action[1:0];
        updNeedRepair <= (repair != 0);
        updCheckPoint <= cp[1:0];
        updTaken      <= taken[0];
        @(posedge clk);
    endtask

    // One Wishbone access, returns on the ack edge
    task automatic wbAccess(input logic write, input logic [1:0] adr, input logic [31:0] data);
        updNeedRepair <= 1'b0;
        wbCyc   <= 1'b1;
        wbStb   <= 1'b1;
        wbWe    <= write;
        wbAdr   <= adr;
        wbWrDat <= data;
        do begin
            @(posedge clk);
        end while (!wbAck);
        wbCyc   <= 1'b0;
        wbStb   <= 1'b0;
        wbWe    <= 1'b0;
        wbWrDat <= '0;
    endtask

    task automatic readRegs();
        wbAccess(1'b0, bpPkg::REG_UPDATES, '0);
        wbAccess(1'b0, bpPkg::REG_MISPRED, '0);
        wbAccess(1'b0, bpPkg::REG_STATUS, '0);
        wbAccess(1'b0, bpPkg::REG_CTRL, '0);
    endtask

    // Every index once, upper hash field zero
    task automatic scanTable();
        int k;
        updNeedRepair <= 1'b0;
        for (k = 0; k < ENTRIES; k++) begin
            fetchVAddr <= 32'(k) << 4;
            @(posedge clk);
        end
    endtask

    task automatic reportAndFinish(input logic timedOut);
        $display("Checks %0d, lookup errors %0d, busy errors %0d, Wishbone errors %0d",
                 checks, lookupErrors, busyErrors, wbErrors);
        if (!timedOut && (lookupErrors + busyErrors + wbErrors) == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    initial begin : watchdog
        wait (cycleCount >= TIMEOUT_CYCLES);
        $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        reportAndFinish(1'b1);
    end

    initial begin : stimulus
        rst           = 1'b0;
        fetchVAddr    = '0;
        updAction     = bpPkg::ACT_NONE;
        updNeedRepair = 1'b0;
        updCheckPoint = '0;
        updVAddr      = '0;
        updTaken      = 1'b0;
        wbCyc         = 1'b0;
        wbStb         = 1'b0;
        wbWe          = 1'b0;
        wbAdr         = '0;
        wbWrDat       = '0;
        lfsrState     = 16'd67;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;

        // Reset sweep runs under random traffic
        repeat (RAND_FIRST) randomCycle();
        readRegs();
        wbAccess(1'b1, bpPkg::REG_CTRL, 32'h2);
        readRegs();
        repeat (RAND_SECOND) randomCycle();
        readRegs();

        // Flush, then a second request while sweeping
        wbAccess(1'b1, bpPkg::REG_CTRL, 32'h1);
        repeat (10) randomCycle();
        wbAccess(1'b1, bpPkg::REG_CTRL, 32'h1);
        // Status shows busy mid-sweep
        readRegs();
        while (busy) begin
            randomCycle();
        end
        scanTable();
        readRegs();

        repeat (RAND_LAST) randomCycle();
        readRegs();
        updNeedRepair <= 1'b0;
        repeat (4) @(posedge clk);
        reportAndFinish(1'b0);
    end

endmodule

/* flist.f */
hdl/bpPkg.sv
hdl/phtBank.sv
hdl/phtUpdate.sv
hdl/phtSweepFsm.sv
hdl/sweepCounter.sv
hdl/phtWbRegs.sv
hdl/patternHistoryTop.sv
tests/phtChecker.sv
tests/patternHistoryTb.sv

/* Bender.yml */
package:
  name: pattern_history

sources:
  - hdl/bpPkg.sv
  - hdl/phtBank.sv
  - hdl/phtUpdate.sv
  - hdl/phtSweepFsm.sv
  - hdl/sweepCounter.sv
  - hdl/phtWbRegs.sv
  - hdl/patternHistoryTop.sv
  - target: test
    files:
      - tests/phtChecker.sv
      - tests/patternHistoryTb.sv
